// File: verilog/wiscPkg.sv
/* WISC core shared types */

package wiscPkg;

	typedef logic [15:0] wordT;			// Data and address word
	typedef logic [2:0] regIdxT;		// One of eight registers

	// ALU function in decoder order
	typedef enum logic [2:0] {
		aluRol = 3'b000,
		aluSll = 3'b001,
		aluRor = 3'b010,
		aluSrl = 3'b011,
		aluAdd = 3'b100,
		aluAnd = 3'b101,
		aluOr  = 3'b110,
		aluXor = 3'b111
	} aluOpT;

	typedef enum logic [1:0] {
		cmpEq = 2'b00,					// Rs == Rt
		cmpLt = 2'b01,					// Rs < Rt signed
		cmpLe = 2'b10,					// Rs <= Rt signed
		cmpCo = 2'b11					// Carry out of Rs + Rt
	} cmpOpT;

	typedef enum logic [1:0] {
		spNone = 2'b00,					// Plain ALU result
		spBtr  = 2'b01,
		spLbi  = 2'b10,
		spSlbi = 2'b11
	} specialOpT;

	typedef enum logic [1:0] {
		dstRs  = 2'b00,					// instr[10:8]
		dstMid = 2'b01,					// instr[7:5]
		dstLow = 2'b10,					// instr[4:2]
		dstR7  = 2'b11					// Link register
	} regDstT;

endpackage

// File: verilog/alu.sv
/* Integer ALU */

`timescale 1ns/100ps

module alu (
	input  wiscPkg::wordT a,
	input  wiscPkg::wordT b,
	input  wiscPkg::aluOpT aluOp,
	input  logic cin,
	input  logic invA,
	input  logic invB,
	input  logic sign,						// Signed overflow select
	output wiscPkg::wordT result,
	output logic carry,
	output logic ofl,
	output logic zero
);
	import wiscPkg::*;

	wordT aIn;
	wordT bIn;
	wordT sum;
	logic [3:0] sh;
	logic [31:0] rotL;
	logic [31:0] rotR;

	assign aIn = invA ? ~a : a;
	assign bIn = invB ? ~b : b;
	assign {carry, sum} = {1'b0, aIn} + {1'b0, bIn} + {16'b0, cin};
	assign sh = bIn[3:0];
	assign rotL = {aIn, aIn} << sh;			// Upper half is the rotate
	assign rotR = {aIn, aIn} >> sh;

	// Signed overflow when like signs give an unlike sum
	assign ofl = sign ? (aIn[15] == bIn[15]) && (sum[15] != aIn[15]) : carry;

	always_comb begin
		case (aluOp)
			aluRol: result = rotL[31:16];
			aluSll: result = aIn << sh;
			aluRor: result = rotR[15:0];
			aluSrl: result = aIn >> sh;
			aluAdd: result = sum;
			aluAnd: result = aIn & bIn;
			aluOr:  result = aIn | bIn;
			default: result = aIn ^ bIn;	// XOR
		endcase
	end

	assign zero = result == '0;

endmodule

// File: verilog/control.sv
/* Instruction decoder */

`timescale 1ns/100ps

module control (
	input  logic [4:0] opCode,
	input  logic [1:0] funct,				// R-format function
	output logic halt,
	output wiscPkg::regDstT regDst,
	output logic imm5,						// 5-bit immediate instead of 8-bit
	output logic signImm,
	output wiscPkg::aluOpT aluOp,
	output logic aluSrc,					// Immediate as ALU operand b
	output logic cin,
	output logic invA,
	output logic invB,
	output logic sign,
	output logic jumpI,						// Register jump
	output logic jumpD,						// Displacement jump
	output logic branch,
	output logic memWrite,
	output logic memRead,
	output logic cmpSet,
	output wiscPkg::cmpOpT cmpOp,
	output logic memToReg,
	output logic regWrite,
	output logic link,						// Write PC+2
	output wiscPkg::specialOpT specialOp,
	output logic siic,
	output logic rti
);
	import wiscPkg::*;

	always_comb begin
		halt = 1'b0;
		regDst = dstRs;
		imm5 = 1'b0;
		signImm = 1'b0;
		aluOp = aluRol;
		aluSrc = 1'b0;
		cin = 1'b0;
		invA = 1'b0;
		invB = 1'b0;
		sign = 1'b1;						// Signed unless SCO
		jumpI = 1'b0;
		jumpD = 1'b0;
		branch = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		cmpSet = 1'b0;
		cmpOp = cmpEq;
		memToReg = 1'b0;
		regWrite = 1'b0;
		link = 1'b0;
		specialOp = spNone;
		siic = 1'b0;
		rti = 1'b0;

		case (opCode)
			5'b00000: halt = 1'b1;
			5'b00001: ;						// NOP
			5'b00010: begin					// siic
				jumpD = 1'b1;
				siic = 1'b1;
			end
			5'b00011: begin					// RTI
				jumpD = 1'b1;
				rti = 1'b1;
			end
			5'b00100: jumpD = 1'b1;			// J
			5'b00101: begin					// JR
				signImm = 1'b1;
				aluOp = aluAdd;
				aluSrc = 1'b1;
				jumpI = 1'b1;
			end
			5'b00110: begin					// JAL
				regDst = dstR7;
				jumpD = 1'b1;
				regWrite = 1'b1;
				link = 1'b1;
			end
			5'b00111: begin					// JALR
				regDst = dstR7;
				signImm = 1'b1;
				aluOp = aluAdd;
				aluSrc = 1'b1;
				jumpI = 1'b1;
				regWrite = 1'b1;
				link = 1'b1;
			end
			5'b01000, 5'b01001, 5'b01010, 5'b01011,
			5'b10100, 5'b10101, 5'b10110, 5'b10111: begin	// Immediate ALU forms
				regDst = dstMid;
				imm5 = 1'b1;
				aluSrc = 1'b1;
				regWrite = 1'b1;
				case (opCode[2:0])
					3'b000: begin			// ADDI
						signImm = 1'b1;
						aluOp = aluAdd;
					end
					3'b001: begin			// SUBI is imm - Rs
						signImm = 1'b1;
						aluOp = aluAdd;
						cin = 1'b1;
						invA = 1'b1;
					end
					3'b010: aluOp = aluXor;
					3'b011: begin			// ANDNI
						aluOp = aluAnd;
						invB = 1'b1;
					end
					default: aluOp = aluOpT'(opCode[1:0]);	// ROLI SLLI RORI SRLI
				endcase
			end
			5'b01100, 5'b01101, 5'b01110, 5'b01111: begin	// Branches
				signImm = 1'b1;
				branch = 1'b1;
			end
			5'b10000, 5'b10001, 5'b10011: begin	// ST LD STU
				imm5 = 1'b1;
				signImm = 1'b1;
				aluOp = aluAdd;
				aluSrc = 1'b1;
				memWrite = !opCode[1] ? !opCode[0] : 1'b1;
				memRead = opCode[1:0] == 2'b01;
				memToReg = opCode[1:0] == 2'b01;
				regWrite = opCode[0];		// LD writes Rd, STU writes Rs
				regDst = opCode[1] ? dstRs : dstMid;
			end
			5'b10010: begin					// SLBI
				signImm = 1'b1;
				regWrite = 1'b1;
				specialOp = spSlbi;
			end
			5'b11000: begin					// LBI
				signImm = 1'b1;
				regWrite = 1'b1;
				specialOp = spLbi;
			end
			5'b11001: begin					// BTR
				regDst = dstLow;
				regWrite = 1'b1;
				specialOp = spBtr;
			end
			5'b11010: begin					// ROL SLL ROR SRL by funct
				regDst = dstLow;
				regWrite = 1'b1;
				aluOp = aluOpT'({1'b0, funct});
			end
			5'b11011: begin					// ADD SUB XOR ANDN
				regDst = dstLow;
				regWrite = 1'b1;
				case (funct)
					2'b00: aluOp = aluAdd;
					2'b01: begin			// Rt - Rs
						aluOp = aluAdd;
						cin = 1'b1;
						invA = 1'b1;
					end
					2'b10: aluOp = aluXor;
					2'b11: begin
						aluOp = aluAnd;
						invB = 1'b1;
					end
				endcase
			end
			5'b11100, 5'b11101, 5'b11110, 5'b11111: begin	// SEQ SLT SLE SCO
				regDst = dstLow;
				regWrite = 1'b1;
				aluOp = aluAdd;
				cmpSet = 1'b1;
				cmpOp = cmpOpT'(opCode[1:0]);
				cin = opCode[1:0] != 2'b11;	// Rs - Rt for the compares
				invB = opCode[1:0] != 2'b11;
				sign = opCode[1:0] != 2'b11;	// SCO wants the raw carry
			end
		endcase
	end

endmodule

// File: verilog/regFile.sv
/* Register file */

`timescale 1ns/100ps

module regFile (
	input  logic clk,
	input  logic arstN,
	input  wiscPkg::regIdxT rdIdxA,
	input  wiscPkg::regIdxT rdIdxB,
	input  wiscPkg::regIdxT wrIdx,
	input  logic wrEn,
	input  wiscPkg::wordT wrData,
	output wiscPkg::wordT rdDataA,
	output wiscPkg::wordT rdDataB
);
	import wiscPkg::*;

	wordT regs [8];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;			// Retire edge
		end
	end

	assign rdDataA = regs[rdIdxA];			// Combinational read ports
	assign rdDataB = regs[rdIdxB];

endmodule

// File: verilog/execute.sv
/* Execute and write-back */

`timescale 1ns/100ps

module execute (
	input  wiscPkg::wordT instr,
	input  wiscPkg::wordT rdDataA,			// Rs
	input  wiscPkg::wordT rdDataB,			// Rt or store data
	input  wiscPkg::wordT pcPlus2,
	input  wiscPkg::wordT memRdata,			// Held load data
	input  logic memDone,
	input  wiscPkg::regDstT regDst,
	input  logic imm5,
	input  logic signImm,
	input  wiscPkg::aluOpT aluOp,
	input  logic aluSrc,
	input  logic cin,
	input  logic invA,
	input  logic invB,
	input  logic sign,
	input  logic branch,
	input  logic cmpSet,
	input  wiscPkg::cmpOpT cmpOp,
	input  logic memToReg,
	input  logic regWrite,
	input  logic link,
	input  wiscPkg::specialOpT specialOp,
	input  logic memRead,
	input  logic memWrite,
	output wiscPkg::regIdxT wrIdx,
	output logic wrEn,
	output wiscPkg::wordT wrData,
	output logic branchTaken,
	output wiscPkg::wordT jumpTarget,		// Rs + imm for JR and JALR
	output wiscPkg::wordT memAddr,
	output wiscPkg::wordT memWdata
);
	import wiscPkg::*;

	wordT immExt;
	wordT aluB;
	wordT aluRes;
	wordT btr;
	logic carry;
	logic ofl;
	logic zero;
	logic cmpBit;
	logic brCond;

	always_comb begin
		if (imm5)
			immExt = signImm ? {{11{instr[4]}}, instr[4:0]} : {11'b0, instr[4:0]};
		else
			immExt = signImm ? {{8{instr[7]}}, instr[7:0]} : {8'b0, instr[7:0]};
	end

	assign aluB = aluSrc ? immExt : rdDataB;

	alu i_alu (
		.a(rdDataA), .b(aluB), .aluOp(aluOp), .cin(cin), .invA(invA), .invB(invB),
		.sign(sign), .result(aluRes), .carry(carry), .ofl(ofl), .zero(zero)
	);

	// Compare on Rs - Rt
	always_comb begin
		case (cmpOp)
			cmpEq: cmpBit = zero;
			cmpLt: cmpBit = aluRes[15] ^ ofl;
			cmpLe: cmpBit = (aluRes[15] ^ ofl) | zero;
			default: cmpBit = carry;		// SCO
		endcase
	end

	always_comb begin
		for (int i = 0; i < 16; i++)
			btr[i] = rdDataA[15 - i];
	end

	// Condition from opcode bits 1:0
	always_comb begin
		case (instr[12:11])
			2'b00: brCond = rdDataA == '0;	// BEQZ
			2'b01: brCond = rdDataA != '0;
			2'b10: brCond = rdDataA[15];		// BLTZ
			default: brCond = !rdDataA[15];
		endcase
	end

	assign branchTaken = branch & brCond;
	assign jumpTarget = aluRes;
	assign memAddr = aluRes;
	assign memWdata = rdDataB;

	always_comb begin
		case (regDst)
			dstRs:  wrIdx = instr[10:8];
			dstMid: wrIdx = instr[7:5];
			dstLow: wrIdx = instr[4:2];
			default: wrIdx = 3'd7;
		endcase
	end

	always_comb begin
		if (link)
			wrData = pcPlus2;
		else if (memToReg)
			wrData = memRdata;
		else if (cmpSet)
			wrData = {15'b0, cmpBit};
		else begin
			case (specialOp)
				spBtr:  wrData = btr;
				spLbi:  wrData = immExt;
				spSlbi: wrData = {rdDataA[7:0], instr[7:0]};
				default: wrData = aluRes;
			endcase
		end
	end

	// Memory forms write only in the done cycle
	assign wrEn = regWrite & (!(memRead | memWrite) | memDone);

endmodule

// File: verilog/pcUnit.sv
/* Program counter and EPC */

`timescale 1ns/100ps

module pcUnit #(
	parameter wiscPkg::wordT resetPc = 16'h0000,
	parameter wiscPkg::wordT excVector = 16'h0002
) (
	input  logic clk,
	input  logic arstN,
	input  logic halt,						// Decoded HALT
	input  logic jumpI,
	input  logic jumpD,
	input  logic siic,
	input  logic rti,
	input  logic branchTaken,
	input  wiscPkg::wordT jumpTarget,
	input  wiscPkg::wordT instr,
	input  logic memBusy,
	output wiscPkg::wordT instrAddr,
	output wiscPkg::wordT pcPlus2,
	output logic halted						// Sticky until reset
);
	import wiscPkg::*;

	wordT pc;
	wordT epc;
	wordT nextPc;
	wordT brTarget;
	wordT dispTarget;
	logic advance;

	assign pcPlus2 = pc + 16'd2;
	assign brTarget = pcPlus2 + {{8{instr[7]}}, instr[7:0]};
	assign dispTarget = pcPlus2 + {{5{instr[10]}}, instr[10:0]};
	assign advance = !halted && !memBusy;	// Retire edge enable

	// siic and rti also carry jumpD so they come first
	always_comb begin
		if (siic)
			nextPc = excVector;
		else if (rti)
			nextPc = epc;
		else if (jumpD)
			nextPc = dispTarget;
		else if (jumpI)
			nextPc = jumpTarget;
		else if (branchTaken)
			nextPc = brTarget;
		else
			nextPc = pcPlus2;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
			halted <= 1'b0;
		end else if (advance) begin
			if (halt)
				halted <= 1'b1;				// PC stays on HALT
			else
				pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && siic)
			epc <= pcPlus2;
	end

	assign instrAddr = pc;

endmodule

// File: verilog/memPort.sv
/* Data memory four-phase requester */

`timescale 1ns/100ps

module memPort (
	input  logic clk,
	input  logic arstN,
	input  logic memRead,
	input  logic memWrite,
	input  logic memAck,
	input  wiscPkg::wordT memRdata,
	output logic memReq,
	output logic memWe,
	output logic memBusy,					// Stalls PC
	output logic memDone,					// Retire cycle
	output wiscPkg::wordT loadData
);
	typedef enum logic [1:0] {stIdle, stReq, stRel, stDone} stateT;

	stateT state;
	logic memOp;

	assign memOp = memRead | memWrite;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: if (memOp && !memAck) state <= stReq;	// Old ack must be gone
				stReq:  if (memAck) state <= stRel;
				stRel:  if (!memAck) state <= stDone;
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stReq && memAck)
			loadData <= memRdata;			// Valid only with ack
	end

	assign memReq = state == stReq;
	assign memWe = memReq & memWrite;
	assign memDone = state == stDone;
	assign memBusy = memOp & !memDone;

endmodule

// File: verilog/wiscCpu.sv
/* Single-cycle WISC core */

`timescale 1ns/100ps

module wiscCpu #(
	parameter wiscPkg::wordT resetPc = 16'h0000,
	parameter wiscPkg::wordT excVector = 16'h0002
) (
	input  logic clk,
	input  logic arstN,
	input  wiscPkg::wordT instr,
	input  logic memAck,
	input  wiscPkg::wordT memRdata,
	output wiscPkg::wordT instrAddr,
	output logic memReq,
	output logic memWe,
	output wiscPkg::wordT memAddr,
	output wiscPkg::wordT memWdata,
	output logic halt
);
	import wiscPkg::*;

	regDstT regDst;
	aluOpT aluOp;
	cmpOpT cmpOp;
	specialOpT specialOp;
	logic haltInstr, imm5, signImm, aluSrc, cin, invA, invB, sign;
	logic jumpI, jumpD, branch, memWrite, memRead, cmpSet, memToReg;
	logic regWrite, link, siic, rti;
	regIdxT wrIdx;
	wordT wrData, rdDataA, rdDataB, pcPlus2, jumpTarget, loadData;
	logic wrEn, branchTaken, memBusy, memDone;

	control i_control (
		.opCode(instr[15:11]), .funct(instr[1:0]), .halt(haltInstr), .regDst(regDst),
		.imm5(imm5), .signImm(signImm), .aluOp(aluOp), .aluSrc(aluSrc), .cin(cin),
		.invA(invA), .invB(invB), .sign(sign), .jumpI(jumpI), .jumpD(jumpD),
		.branch(branch), .memWrite(memWrite), .memRead(memRead), .cmpSet(cmpSet),
		.cmpOp(cmpOp), .memToReg(memToReg), .regWrite(regWrite), .link(link),
		.specialOp(specialOp), .siic(siic), .rti(rti)
	);

	regFile i_regFile (
		.clk(clk), .arstN(arstN), .rdIdxA(instr[10:8]), .rdIdxB(instr[7:5]),
		.wrIdx(wrIdx), .wrEn(wrEn), .wrData(wrData), .rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	execute i_execute (
		.instr(instr), .rdDataA(rdDataA), .rdDataB(rdDataB), .pcPlus2(pcPlus2),
		.memRdata(loadData), .memDone(memDone), .regDst(regDst), .imm5(imm5),
		.signImm(signImm), .aluOp(aluOp), .aluSrc(aluSrc), .cin(cin), .invA(invA),
		.invB(invB), .sign(sign), .branch(branch), .cmpSet(cmpSet), .cmpOp(cmpOp),
		.memToReg(memToReg), .regWrite(regWrite), .link(link), .specialOp(specialOp),
		.memRead(memRead), .memWrite(memWrite), .wrIdx(wrIdx), .wrEn(wrEn),
		.wrData(wrData), .branchTaken(branchTaken), .jumpTarget(jumpTarget),
		.memAddr(memAddr), .memWdata(memWdata)
	);

	pcUnit #(.resetPc(resetPc), .excVector(excVector)) i_pcUnit (
		.clk(clk), .arstN(arstN), .halt(haltInstr), .jumpI(jumpI), .jumpD(jumpD),
		.siic(siic), .rti(rti), .branchTaken(branchTaken), .jumpTarget(jumpTarget),
		.instr(instr), .memBusy(memBusy), .instrAddr(instrAddr), .pcPlus2(pcPlus2),
		.halted(halt)
	);

	memPort i_memPort (
		.clk(clk), .arstN(arstN), .memRead(memRead), .memWrite(memWrite),
		.memAck(memAck), .memRdata(memRdata), .memReq(memReq), .memWe(memWe),
		.memBusy(memBusy), .memDone(memDone), .loadData(loadData)
	);

endmodule

// File: tb/memPort_properties.sv
/* Memory handshake assertions */

`timescale 1ns/100ps

module memPort_properties (
	input logic clk,
	input logic arstN,
	input logic memReq,
	input logic memAck,
	input logic memWe,
	input wiscPkg::wordT memAddr,
	input logic memDone
);

	reqHold: assert property (@(posedge clk) disable iff (!arstN)
		memReq && !memAck |=> memReq) else $error("memReq dropped before memAck");

	noReqOnAck: assert property (@(posedge clk) disable iff (!arstN)
		$rose(memReq) |-> !memAck) else $error("memReq rose while memAck high");

	// Address and direction fixed for the whole request
	reqStable: assert property (@(posedge clk) disable iff (!arstN)
		memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWe))
		else $error("request changed while memReq high");

	doneOne: assert property (@(posedge clk) disable iff (!arstN)
		memDone |=> !memDone) else $error("memDone longer than one cycle");

endmodule

// File: tb/wiscCpuTb.sv
/* WISC core testbench */

`timescale 1ns/100ps

module wiscCpuTb;
	import wiscPkg::*;

	localparam wordT resetPc = 16'h0180;
	localparam wordT excVector = 16'h0100;

	// Opcodes from the ISA listing
	localparam logic [4:0] opHalt = 5'b00000, opSiic = 5'b00010, opRti = 5'b00011;
	localparam logic [4:0] opJ = 5'b00100, opJr = 5'b00101, opJal = 5'b00110;
	localparam logic [4:0] opJalr = 5'b00111, opAddi = 5'b01000, opSubi = 5'b01001;
	localparam logic [4:0] opXori = 5'b01010, opAndni = 5'b01011, opBeqz = 5'b01100;
	localparam logic [4:0] opBnez = 5'b01101, opBltz = 5'b01110, opBgez = 5'b01111;
	localparam logic [4:0] opSt = 5'b10000, opLd = 5'b10001, opSlbi = 5'b10010;
	localparam logic [4:0] opStu = 5'b10011, opRoli = 5'b10100, opSrli = 5'b10111;
	localparam logic [4:0] opLbi = 5'b11000, opBtr = 5'b11001, opShift = 5'b11010;
	localparam logic [4:0] opArith = 5'b11011, opSeq = 5'b11100, opSlt = 5'b11101;
	localparam logic [4:0] opSle = 5'b11110, opSco = 5'b11111;

	logic clk;
	logic arstN;
	wordT instr, instrAddr, memAddr, memWdata;
	wordT memRdata = '0;					// Responder outputs start idle
	logic memAck = 1'b0;
	logic memReq, memWe, halt;

	wordT rom [256];						// Word indexed program
	wordT dmem [256];
	wordT stAddrQ [$];						// Observed stores in order
	wordT stDataQ [$];
	logic [15:0] lfsr;
	logic [1:0] delay;
	int cycles;
	int limit;

	string rowName [64];					// Trace table
	wordT rowPc [64];
	bit rowSt [64];
	wordT rowAddr [64];
	wordT rowData [64];
	int nRows;

	wiscCpu #(.resetPc(resetPc), .excVector(excVector)) i_wiscCpu (
		.clk(clk), .arstN(arstN), .instr(instr), .memAck(memAck), .memRdata(memRdata),
		.instrAddr(instrAddr), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
		.memWdata(memWdata), .halt(halt)
	);

	bind wiscCpu memPort_properties i_memPortProps (
		.clk(clk), .arstN(arstN), .memReq(memReq), .memAck(memAck), .memWe(memWe),
		.memAddr(memAddr), .memDone(memDone)
	);

	assign instr = rom[instrAddr[8:1]];		// Asynchronous fetch

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];	// Taps 16 14 13 11
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [1:0] randDelay();
		logic b0;
		logic b1;
		b0 = lfsrBit();
		b1 = lfsrBit();
		return {b1, b0};
	endfunction

	// Instruction formats
	function automatic wordT ri(input logic [4:0] op, input regIdxT rs, input regIdxT rd,
			input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic wordT i2(input logic [4:0] op, input regIdxT rs, input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic wordT rr(input logic [4:0] op, input regIdxT rs, input regIdxT rt,
			input regIdxT rd, input logic [1:0] fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic wordT jf(input logic [4:0] op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic step(input string nm, input wordT pc, input wordT ins);
		rom[pc[8:1]] = ins;
		rowName[nRows] = nm;
		rowPc[nRows] = pc;
		rowSt[nRows] = 1'b0;
		nRows++;
	endtask

	task automatic stepSt(input string nm, input wordT pc, input wordT ins, input wordT a,
			input wordT d);
		step(nm, pc, ins);
		rowSt[nRows - 1] = 1'b1;
		rowAddr[nRows - 1] = a;
		rowData[nRows - 1] = d;
	endtask

	task automatic valueFail(input string nm, input wordT exp, input wordT act);
		$display("CHECK FAILED %s expected %h actual %h", nm, exp, act);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// Data memory responder with random ack and release delay
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memAck <= 1'b0;
			memRdata <= '0;
			delay <= 2'd0;
		end else if (memReq && !memAck) begin
			if (delay == 2'd0) begin
				memAck <= 1'b1;
				delay <= randDelay();
				if (memWe) begin
					dmem[memAddr[8:1]] <= memWdata;
					stAddrQ.push_back(memAddr);
					stDataQ.push_back(memWdata);
				end else begin
					memRdata <= dmem[memAddr[8:1]];
				end
			end else begin
				delay <= delay - 2'd1;
			end
		end else if (!memReq && memAck) begin
			if (delay == 2'd0) begin
				memAck <= 1'b0;
				delay <= randDelay();
			end else begin
				delay <= delay - 2'd1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: trace did not finish within %0d cycles", limit);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	initial begin
		wordT lastPc;
		wordT a;
		wordT d;
		arstN = 1'b0;
		lfsr = 16'd39;
		cycles = 0;
		limit = 1000;
		nRows = 0;
		for (int i = 0; i < 256; i++) begin
			rom[i] = 16'h0000;				// Stray fetches halt
			dmem[i] = {8'(i), ~8'(i)};
		end
		// Reset vector jumps back by 0x182 to the program at 0
		step("resetJ", 16'h180, jf(opJ, 11'h67E));
		// r1 = 0x1234, r2 = 0xFFF0, r6 = store base 0x40
		step("lbi", 16'h00, i2(opLbi, 1, 8'h12));
		step("slbi", 16'h02, i2(opSlbi, 1, 8'h34));
		step("lbiNeg", 16'h04, i2(opLbi, 2, 8'hF0));
		step("lbiBase", 16'h06, i2(opLbi, 6, 8'h40));
		stepSt("stSlbi", 16'h08, ri(opSt, 6, 1, 5'd0), 16'h40, 16'h1234);
		step("addi", 16'h0A, ri(opAddi, 1, 3, 5'd5));
		stepSt("stAddi", 16'h0C, ri(opSt, 6, 3, 5'd2), 16'h42, 16'h1239);
		step("subi", 16'h0E, ri(opSubi, 1, 3, 5'd3));
		stepSt("stSubi", 16'h10, ri(opSt, 6, 3, 5'd4), 16'h44, 16'hEDCF);
		step("xori", 16'h12, ri(opXori, 1, 3, 5'h1F));
		stepSt("stXori", 16'h14, ri(opSt, 6, 3, 5'd6), 16'h46, 16'h122B);
		step("andni", 16'h16, ri(opAndni, 1, 3, 5'h0F));
		stepSt("stAndni", 16'h18, ri(opSt, 6, 3, 5'd8), 16'h48, 16'h1230);
		step("roli", 16'h1A, ri(opRoli, 1, 3, 5'd4));
		stepSt("stRoli", 16'h1C, ri(opSt, 6, 3, 5'd10), 16'h4A, 16'h2341);
		step("srli", 16'h1E, ri(opSrli, 2, 3, 5'd4));
		stepSt("stSrli", 16'h20, ri(opSt, 6, 3, 5'd12), 16'h4C, 16'h0FFF);
		step("add", 16'h22, rr(opArith, 1, 2, 4, 2'b00));
		stepSt("stAdd", 16'h24, ri(opSt, 6, 4, 5'd14), 16'h4E, 16'h1224);
		step("sub", 16'h26, rr(opArith, 1, 2, 4, 2'b01));
		stepSt("stSub", 16'h28, ri(opSt, 6, 4, 5'h1E), 16'h3E, 16'hEDBC);
		step("andn", 16'h2A, rr(opArith, 1, 2, 4, 2'b11));
		stepSt("stAndn", 16'h2C, ri(opSt, 6, 4, 5'h1C), 16'h3C, 16'h0004);
		step("lbiSh", 16'h2E, i2(opLbi, 5, 8'h03));
		step("ror", 16'h30, rr(opShift, 1, 5, 4, 2'b10));
		stepSt("stRor", 16'h32, ri(opSt, 6, 4, 5'h1A), 16'h3A, 16'h8246);
		step("btr", 16'h34, rr(opBtr, 1, 0, 4, 2'b00));
		stepSt("stBtr", 16'h36, ri(opSt, 6, 4, 5'h18), 16'h38, 16'h2C48);
		step("slt", 16'h38, rr(opSlt, 2, 1, 4, 2'b00));
		stepSt("stSlt", 16'h3A, ri(opSt, 6, 4, 5'h16), 16'h36, 16'h0001);
		step("seq", 16'h3C, rr(opSeq, 1, 2, 4, 2'b00));
		stepSt("stSeq", 16'h3E, ri(opSt, 6, 4, 5'h14), 16'h34, 16'h0000);
		step("sle", 16'h40, rr(opSle, 2, 2, 4, 2'b00));
		stepSt("stSle", 16'h42, ri(opSt, 6, 4, 5'h12), 16'h32, 16'h0001);
		step("sco", 16'h44, rr(opSco, 1, 2, 4, 2'b00));
		stepSt("stSco", 16'h46, ri(opSt, 6, 4, 5'h10), 16'h30, 16'h0001);
		// Loads, then STU moves the base to 0x44
		step("ld", 16'h48, ri(opLd, 6, 5, 5'd2));
		stepSt("stLd", 16'h4A, ri(opSt, 6, 5, 5'd0), 16'h40, 16'h1239);
		stepSt("stu", 16'h4C, ri(opStu, 6, 1, 5'd4), 16'h44, 16'h1234);
		stepSt("stStuBase", 16'h4E, ri(opSt, 6, 6, 5'd0), 16'h44, 16'h0044);
		step("ldFill", 16'h50, ri(opLd, 6, 5, 5'd12));
		stepSt("stLdFill", 16'h52, ri(opSt, 6, 5, 5'd0), 16'h44, 16'h28D7);
		// Control flow with r4 = 1 and r2 negative
		step("beqzNot", 16'h54, i2(opBeqz, 4, 8'd4));
		step("bnezTaken", 16'h56, i2(opBnez, 4, 8'd2));
		step("bltzTaken", 16'h5A, i2(opBltz, 2, 8'd2));
		step("bgezNot", 16'h5E, i2(opBgez, 2, 8'd8));
		step("j", 16'h60, jf(opJ, 11'd4));
		step("jal", 16'h66, jf(opJal, 11'd6));
		stepSt("stJal", 16'h6E, ri(opSt, 6, 7, 5'd0), 16'h44, 16'h0068);
		step("lbiJr", 16'h70, i2(opLbi, 5, 8'h78));
		step("jr", 16'h72, i2(opJr, 5, 8'h04));
		step("jalr", 16'h7C, i2(opJalr, 5, 8'h10));
		stepSt("stJalr", 16'h88, ri(opSt, 6, 7, 5'd0), 16'h44, 16'h007E);
		step("siic", 16'h8A, jf(opSiic, 11'd0));
		step("handler", 16'h100, i2(opLbi, 3, 8'h55));
		step("rti", 16'h102, jf(opRti, 11'd0));
		stepSt("stHandler", 16'h8C, ri(opSt, 6, 3, 5'd0), 16'h44, 16'h0055);
		step("halt", 16'h8E, jf(opHalt, 11'd0));
		limit = nRows * 10 + 50;

		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (instrAddr == resetPc) else valueFail("resetPc", resetPc, instrAddr);
		assert (!memReq) else valueFail("resetReq", 16'h0, {15'b0, memReq});
		assert (!halt) else valueFail("resetHalt", 16'h0, {15'b0, halt});
		@(posedge clk);
		arstN <= 1'b1;

		lastPc = instrAddr;
		for (int i = 0; i < nRows; i++) begin
			while (i > 0 && instrAddr == lastPc)
				@(negedge clk);				// Stalled on memory
			assert (instrAddr == rowPc[i]) else valueFail(rowName[i], rowPc[i], instrAddr);
			lastPc = instrAddr;
			if (rowSt[i]) begin
				while (stAddrQ.size() == 0)
					@(negedge clk);
				a = stAddrQ.pop_front();
				d = stDataQ.pop_front();
				assert (a == rowAddr[i]) else valueFail(rowName[i], rowAddr[i], a);
				assert (d == rowData[i]) else valueFail(rowName[i], rowData[i], d);
			end
		end

		// HALT freezes the PC
		repeat (2) @(negedge clk);
		assert (halt) else valueFail("haltFlag", 16'h1, {15'b0, halt});
		repeat (5) begin
			@(negedge clk);
			assert (instrAddr == lastPc) else valueFail("haltPc", lastPc, instrAddr);
		end
		assert (stAddrQ.size() == 0) else begin
			$display("Unexpected extra store to data memory");
			$display("TB FAILED");
			$fatal(1);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: src.f
verilog/wiscPkg.sv
verilog/alu.sv
verilog/control.sv
verilog/regFile.sv
verilog/execute.sv
verilog/pcUnit.sv
verilog/memPort.sv
verilog/wiscCpu.sv
tb/memPort_properties.sv
tb/wiscCpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= wiscCpuTb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
FILE_LIST ?= src.f

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)
